//--- design/host_chan_pkg.sv
// Shared types of the host memory channel
// Avalon read and write request structs, CCI-P request and response structs,
// the request type encoding and the CCI-P burst length types
package host_chan_pkg;

    // Width of a line address and of one line of data
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;

    // CCI-P burst length minus one, and line index within a burst
    typedef logic [1:0] t_cl_len;
    typedef logic [1:0] t_cl_num;

    // CCI-P request encoding, one bit is enough for the two commands used here
    typedef enum logic
    {
        RDLINE = 1'b0,
        WRLINE = 1'b1
    } t_req_type;

    // Avalon read request, burstcount is fixed at 8 bits so bursts stop at 128
    typedef struct packed
    {
        logic              read;
        logic [ADDR_W-1:0] address;
        logic [7:0]        burstcount;
    } t_avmm_rd_req;

    // Avalon write beat
    // Address and burstcount only count on the first beat of a burst
    typedef struct packed
    {
        logic              write;
        logic [ADDR_W-1:0] address;
        logic [7:0]        burstcount;
        logic [DATA_W-1:0] writedata;
    } t_avmm_wr_req;

    // CCI-P c0 read request
    typedef struct packed
    {
        logic              valid;
        logic [ADDR_W-1:0] address;
        t_req_type         req_type;
        t_cl_len           cl_len;
    } t_c0_tx;

    // CCI-P c1 write request, one line per cycle with sop on the first line
    typedef struct packed
    {
        logic              valid;
        logic              sop;
        logic [ADDR_W-1:0] address;
        t_req_type         req_type;
        t_cl_len           cl_len;
        logic              mdata;
        logic [DATA_W-1:0] data;
    } t_c1_tx;

    // Host responses, already sorted in request order
    typedef struct packed
    {
        logic              rsp_valid;
        logic [DATA_W-1:0] data;
    } t_c0_rx;

    typedef struct packed
    {
        logic rsp_valid;
        logic mdata;
    } t_c1_rx;

    // Everything the host sends back, including the flow control bits
    typedef struct packed
    {
        t_c0_rx c0;
        t_c1_rx c1;
        logic   c0_alm_full;
        logic   c1_alm_full;
    } t_host_rx;

endpackage

//--- design/avmm_burst_splitter.sv
// Avalon burst splitter
// Cuts accelerator read and write bursts into naturally aligned bursts
// of one, two or four lines and flags the write piece that owns the response
`timescale 1ns/10ps

module avmm_burst_splitter
    import host_chan_pkg::*;
#(
    parameter int MAX_BURST = 16
)
(
    input  logic         clk,
    input  logic         reset,
    input  t_avmm_rd_req afu_rd,
    input  t_avmm_wr_req afu_wr,
    output logic         afu_rd_waitrequest,
    output logic         afu_wr_waitrequest,
    output t_avmm_rd_req fiu_rd,
    output t_avmm_wr_req fiu_wr,
    input  logic         fiu_rd_waitrequest,
    input  logic         fiu_wr_waitrequest,
    output logic         wr_expects_response
);

    // Remaining line counters only need to hold MAX_BURST
    localparam int CNT_W = $clog2(MAX_BURST + 1);

    // Largest naturally aligned piece that fits in the remaining lines
    function automatic logic [2:0] piece_len(input logic [1:0] lo,
                                             input logic [CNT_W-1:0] remain);
        logic [2:0] len;
        if ((lo == 2'b00) && (remain >= 4))
        begin
            len = 3'd4;
        end
        else if (!lo[0] && (remain >= 2))
        begin
            len = 3'd2;
        end
        else
        begin
            len = 3'd1;
        end
        return len;
    endfunction

    // Read path
    logic              rd_out_ready;
    logic              rd_take;
    logic              rd_busy;
    logic [CNT_W-1:0]  rd_remain;
    logic [ADDR_W-1:0] rd_addr;
    logic [ADDR_W-1:0] rd_cur_addr;
    logic [CNT_W-1:0]  rd_cur_remain;
    logic [2:0]        rd_len;

    // The output register is free when empty or when the bridge takes it
    assign rd_out_ready = !fiu_rd.read || !fiu_rd_waitrequest;

    // A burst stays blocked until its last piece has gone out
    assign afu_rd_waitrequest = rd_busy || !rd_out_ready;
    assign rd_take = rd_out_ready && (rd_busy || afu_rd.read);

    // While busy the pieces come from the saved state, not from the input
    assign rd_cur_addr = rd_busy ? rd_addr : afu_rd.address;
    assign rd_cur_remain = rd_busy ? rd_remain : CNT_W'(afu_rd.burstcount);
    assign rd_len = piece_len(rd_cur_addr[1:0], rd_cur_remain);

    always_ff @(posedge clk)
    begin
        if (rd_take)
        begin
            fiu_rd.read <= 1'b1;
            fiu_rd.address <= rd_cur_addr;
            fiu_rd.burstcount <= 8'(rd_len);
            rd_addr <= rd_cur_addr + ADDR_W'(rd_len);
            rd_remain <= rd_cur_remain - CNT_W'(rd_len);
            rd_busy <= (rd_cur_remain != CNT_W'(rd_len));
        end
        else if (rd_out_ready)
        begin
            fiu_rd.read <= 1'b0;
        end

        if (reset)
        begin
            fiu_rd.read <= 1'b0;
            rd_busy <= 1'b0;
        end
    end

    // Write path
    logic              wr_out_ready;
    logic              wr_accept;
    logic              wr_in_burst;
    logic              wr_piece_start;
    logic [1:0]        wr_piece_left;
    logic [CNT_W-1:0]  wr_remain;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] wr_cur_addr;
    logic [CNT_W-1:0]  wr_cur_remain;
    logic [2:0]        wr_len;

    assign wr_out_ready = !fiu_wr.write || !fiu_wr_waitrequest;
    assign afu_wr_waitrequest = !wr_out_ready;
    assign wr_accept = afu_wr.write && wr_out_ready;

    // Only the first beat of an accelerator burst carries address and count
    assign wr_cur_addr = wr_in_burst ? wr_addr : afu_wr.address;
    assign wr_cur_remain = wr_in_burst ? wr_remain : CNT_W'(afu_wr.burstcount);
    assign wr_piece_start = (wr_piece_left == 2'd0);
    assign wr_len = piece_len(wr_cur_addr[1:0], wr_cur_remain);

    always_ff @(posedge clk)
    begin
        if (wr_accept)
        begin
            fiu_wr.write <= 1'b1;
            fiu_wr.writedata <= afu_wr.writedata;

            // A new piece header goes out at every piece boundary
            if (wr_piece_start)
            begin
                fiu_wr.address <= wr_cur_addr;
                fiu_wr.burstcount <= 8'(wr_len);
                wr_expects_response <= (wr_cur_remain == CNT_W'(wr_len));
                wr_piece_left <= 2'(wr_len - 3'd1);
            end
            else
            begin
                wr_piece_left <= wr_piece_left - 2'd1;
            end

            wr_addr <= wr_cur_addr + ADDR_W'(1);
            wr_remain <= wr_cur_remain - CNT_W'(1);
            wr_in_burst <= (wr_cur_remain != CNT_W'(1));
        end
        else if (wr_out_ready)
        begin
            fiu_wr.write <= 1'b0;
        end

        if (reset)
        begin
            fiu_wr.write <= 1'b0;
            wr_in_burst <= 1'b0;
            wr_piece_left <= 2'd0;
            wr_expects_response <= 1'b0;
        end
    end

endmodule

//--- design/ccip_avmm_bridge.sv
// Avalon to CCI-P bridge
// Turns legal Avalon bursts into c0 read and c1 write request headers,
// maps almost-full to waitrequest and forwards the sorted responses
`timescale 1ns/10ps

module ccip_avmm_bridge
    import host_chan_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  t_avmm_rd_req      fiu_rd,
    input  t_avmm_wr_req      fiu_wr,
    input  logic              wr_expects_response,
    output logic              rd_waitrequest,
    output logic              wr_waitrequest,
    output logic              rd_readdatavalid,
    output logic [DATA_W-1:0] rd_readdata,
    output logic              wr_writeresponsevalid,
    output t_c0_tx            c0_tx,
    output t_c1_tx            c1_tx,
    input  t_host_rx          host_rx
);

    // Host almost-full becomes Avalon waitrequest one cycle later
    always_ff @(posedge clk)
    begin
        rd_waitrequest <= host_rx.c0_alm_full;
        wr_waitrequest <= host_rx.c1_alm_full;

        if (reset)
        begin
            rd_waitrequest <= 1'b0;
            wr_waitrequest <= 1'b0;
        end
    end

    // Reads map one to one onto c0 headers
    always_ff @(posedge clk)
    begin
        c0_tx.valid <= fiu_rd.read && !rd_waitrequest;
        c0_tx.address <= fiu_rd.address;
        c0_tx.req_type <= RDLINE;
        c0_tx.cl_len <= t_cl_len'(fiu_rd.burstcount - 8'd1);

        if (reset)
        begin
            c0_tx.valid <= 1'b0;
        end
    end

    // Read responses arrive sorted, so they are passed on directly
    always_ff @(posedge clk)
    begin
        rd_readdatavalid <= host_rx.c0.rsp_valid;
        rd_readdata <= host_rx.c0.data;

        if (reset)
        begin
            rd_readdatavalid <= 1'b0;
        end
    end

    // Write packet tracking
    logic    wr_beat;
    logic    wr_sop;
    logic    wr_eop;
    t_cl_len wr_cl_len;
    t_cl_num wr_cl_num;
    t_cl_num wr_cl_addr;

    assign wr_beat = fiu_wr.write && !wr_waitrequest;

    // A packet ends on a single-line sop or when the last counted line arrives
    assign wr_eop = (wr_sop && (fiu_wr.burstcount == 8'd1)) ||
                    (!wr_sop && (wr_cl_num == t_cl_num'(wr_cl_len)));

    always_ff @(posedge clk)
    begin
        c1_tx.valid <= wr_beat;
        c1_tx.data <= fiu_wr.writedata;
        c1_tx.sop <= wr_sop;

        // The header is taken on sop; later lines only patch the low address bits
        if (wr_sop)
        begin
            c1_tx.address <= fiu_wr.address;
            c1_tx.req_type <= WRLINE;
            c1_tx.cl_len <= t_cl_len'(fiu_wr.burstcount - 8'd1);
            c1_tx.mdata <= wr_expects_response;
        end
        else
        begin
            c1_tx.address[1:0] <= wr_cl_addr | wr_cl_num;
        end

        if (wr_beat)
        begin
            if (wr_sop)
            begin
                wr_cl_len <= t_cl_len'(fiu_wr.burstcount - 8'd1);
                wr_cl_addr <= t_cl_num'(fiu_wr.address[1:0]);
            end

            if (wr_eop)
            begin
                wr_sop <= 1'b1;
                wr_cl_num <= t_cl_num'(0);
            end
            else
            begin
                wr_sop <= 1'b0;
                wr_cl_num <= wr_cl_num + t_cl_num'(1);
            end
        end

        if (reset)
        begin
            c1_tx.valid <= 1'b0;
            wr_sop <= 1'b1;
            wr_cl_len <= t_cl_len'(0);
            wr_cl_num <= t_cl_num'(0);
        end
    end

    // Only the piece flagged in mdata produces an Avalon write response
    always_ff @(posedge clk)
    begin
        wr_writeresponsevalid <= host_rx.c1.rsp_valid && host_rx.c1.mdata;

        if (reset)
        begin
            wr_writeresponsevalid <= 1'b0;
        end
    end

endmodule

//--- design/host_mem_emulator.sv
// Host memory emulator
// Line memory serving CCI-P reads in request order from a 4-entry header FIFO,
// storing write lines at once and returning one response per write packet
`timescale 1ns/10ps

module host_mem_emulator
    import host_chan_pkg::*;
#(
    parameter int MEM_ADDR_W = 6
)
(
    input  logic     clk,
    input  logic     reset,
    input  t_c0_tx   c0_tx,
    input  t_c1_tx   c1_tx,
    output t_host_rx host_rx
);

    logic [DATA_W-1:0] mem [2**MEM_ADDR_W];

    // Read header FIFO and the line index within the head request
    logic [ADDR_W-1:0]     rq_addr [4];
    t_cl_len               rq_len [4];
    logic [1:0]            rq_wr_ptr;
    logic [1:0]            rq_rd_ptr;
    logic [2:0]            rq_count;
    t_cl_num               rd_idx;
    logic                  rq_push;
    logic                  rq_pop;
    logic [MEM_ADDR_W-1:0] rd_line;
    logic                  c0_rsp_valid;
    logic [DATA_W-1:0]     c0_rsp_data;

    assign rq_push = c0_tx.valid && (c0_tx.req_type == RDLINE);

    // The head leaves the FIFO with its last line
    assign rq_pop = (rq_count != 3'd0) && (rd_idx == t_cl_num'(rq_len[rq_rd_ptr]));
    assign rd_line = rq_addr[rq_rd_ptr][MEM_ADDR_W-1:0] + MEM_ADDR_W'(rd_idx);

    always_ff @(posedge clk)
    begin
        if (rq_push)
        begin
            rq_addr[rq_wr_ptr] <= c0_tx.address;
            rq_len[rq_wr_ptr] <= c0_tx.cl_len;
            rq_wr_ptr <= rq_wr_ptr + 2'd1;
        end

        // One line per cycle while a request is held
        c0_rsp_valid <= (rq_count != 3'd0);
        c0_rsp_data <= mem[rd_line];
        if (rq_pop)
        begin
            rd_idx <= t_cl_num'(0);
            rq_rd_ptr <= rq_rd_ptr + 2'd1;
        end
        else if (rq_count != 3'd0)
        begin
            rd_idx <= rd_idx + t_cl_num'(1);
        end

        rq_count <= rq_count + 3'(rq_push) - 3'(rq_pop);

        if (reset)
        begin
            rq_wr_ptr <= 2'd0;
            rq_rd_ptr <= 2'd0;
            rq_count <= 3'd0;
            rd_idx <= t_cl_num'(0);
            c0_rsp_valid <= 1'b0;
        end
    end

    // Write packet state
    logic    wr_line;
    logic    wr_eop;
    t_cl_len wr_cl_len;
    t_cl_num wr_cnt;
    logic    wr_mdata;
    logic    c1_rsp_valid;
    logic    c1_rsp_mdata;

    assign wr_line = c1_tx.valid && (c1_tx.req_type == WRLINE);
    assign wr_eop = c1_tx.sop ? (c1_tx.cl_len == t_cl_len'(0)) :
                                (wr_cnt == t_cl_num'(wr_cl_len));

    always_ff @(posedge clk)
    begin
        if (wr_line)
        begin
            mem[c1_tx.address[MEM_ADDR_W-1:0]] <= c1_tx.data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_line)
        begin
            if (c1_tx.sop)
            begin
                wr_cl_len <= c1_tx.cl_len;
                wr_mdata <= c1_tx.mdata;
                wr_cnt <= t_cl_num'(1);
            end
            else
            begin
                wr_cnt <= wr_cnt + t_cl_num'(1);
            end
        end

        // A packed response follows the last line, echoing the sop mdata
        c1_rsp_valid <= wr_line && wr_eop;
        c1_rsp_mdata <= c1_tx.sop ? c1_tx.mdata : wr_mdata;

        if (reset)
        begin
            wr_cnt <= t_cl_num'(0);
            c1_rsp_valid <= 1'b0;
        end
    end

    // Two held reads leave room for the requests already in flight
    always_comb
    begin
        host_rx.c0.rsp_valid = c0_rsp_valid;
        host_rx.c0.data = c0_rsp_data;
        host_rx.c1.rsp_valid = c1_rsp_valid;
        host_rx.c1.mdata = c1_rsp_mdata;
        host_rx.c0_alm_full = (rq_count >= 3'd2);
        host_rx.c1_alm_full = 1'b0;
    end

endmodule

//--- design/host_mem_subsys.sv
// Host memory subsystem top level
// Connects the burst splitter, the CCI-P bridge and the host memory emulator
`timescale 1ns/10ps

module host_mem_subsys
    import host_chan_pkg::*;
#(
    parameter int MAX_BURST  = 16,
    parameter int MEM_ADDR_W = 6
)
(
    input  logic              clk,
    input  logic              reset,
    input  t_avmm_rd_req      rd_req,
    input  t_avmm_wr_req      wr_req,
    output logic              rd_waitrequest,
    output logic              wr_waitrequest,
    output logic              rd_readdatavalid,
    output logic [DATA_W-1:0] rd_readdata,
    output logic              wr_writeresponsevalid
);

    // Legal bursts between the splitter and the bridge
    t_avmm_rd_req fiu_rd;
    t_avmm_wr_req fiu_wr;
    logic         fiu_rd_waitrequest;
    logic         fiu_wr_waitrequest;
    logic         wr_expects_response;

    // CCI-P channel between the bridge and the emulator
    t_c0_tx   c0_tx;
    t_c1_tx   c1_tx;
    t_host_rx host_rx;

    avmm_burst_splitter #(
        .MAX_BURST(MAX_BURST)
    ) splitter_i (
        .clk(clk),
        .reset(reset),
        .afu_rd(rd_req),
        .afu_wr(wr_req),
        .afu_rd_waitrequest(rd_waitrequest),
        .afu_wr_waitrequest(wr_waitrequest),
        .fiu_rd(fiu_rd),
        .fiu_wr(fiu_wr),
        .fiu_rd_waitrequest(fiu_rd_waitrequest),
        .fiu_wr_waitrequest(fiu_wr_waitrequest),
        .wr_expects_response(wr_expects_response)
    );

    // Responses go straight from the bridge to the accelerator
    ccip_avmm_bridge bridge_i (
        .clk(clk),
        .reset(reset),
        .fiu_rd(fiu_rd),
        .fiu_wr(fiu_wr),
        .wr_expects_response(wr_expects_response),
        .rd_waitrequest(fiu_rd_waitrequest),
        .wr_waitrequest(fiu_wr_waitrequest),
        .rd_readdatavalid(rd_readdatavalid),
        .rd_readdata(rd_readdata),
        .wr_writeresponsevalid(wr_writeresponsevalid),
        .c0_tx(c0_tx),
        .c1_tx(c1_tx),
        .host_rx(host_rx)
    );

    host_mem_emulator #(
        .MEM_ADDR_W(MEM_ADDR_W)
    ) emulator_i (
        .clk(clk),
        .reset(reset),
        .c0_tx(c0_tx),
        .c1_tx(c1_tx),
        .host_rx(host_rx)
    );

endmodule

//--- tb/host_mem_subsys_checker.sv
// Concurrent assertions on the CCI-P channel inside the host memory subsystem
// Packet framing on c1, burst alignment and length on c0 and c1, quiet reset
// The bind at the bottom attaches the checker to every host_mem_subsys instance
`timescale 1ns/10ps

module host_mem_subsys_checker
    import host_chan_pkg::*;
(
    input logic   clk,
    input logic   reset,
    input t_c0_tx c0_tx,
    input t_c1_tx c1_tx
);

    // Number of assertion failures, read by the testbench at the end of the run
    int fail_count = 0;

    // Tracks whether a multi-line c1 packet has started and not yet ended
    logic    pkt_open;
    t_cl_len pkt_len;
    t_cl_num pkt_cnt;

    always_ff @(posedge clk)
    begin
        if (c1_tx.valid)
        begin
            if (c1_tx.sop)
            begin
                pkt_open <= (c1_tx.cl_len != t_cl_len'(0));
                pkt_len <= c1_tx.cl_len;
                pkt_cnt <= t_cl_num'(1);
            end
            else
            begin
                pkt_cnt <= pkt_cnt + t_cl_num'(1);
                // The packet closes on its last counted line
                if (pkt_cnt == t_cl_num'(pkt_len))
                begin
                    pkt_open <= 1'b0;
                end
            end
        end

        if (reset)
        begin
            pkt_open <= 1'b0;
            pkt_cnt <= t_cl_num'(0);
        end
    end

    // A new packet may only start once the previous one has received all its lines
    sop_inside_packet: assert property (@(posedge clk) disable iff (reset)
        (c1_tx.valid && c1_tx.sop) |-> !pkt_open)
    else
    begin
        $error("c1 sop arrived while a write packet was still open");
        fail_count++;
    end

    // Start offset plus length must stay inside one naturally aligned 4-line block
    c0_crosses_block: assert property (@(posedge clk) disable iff (reset)
        c0_tx.valid |-> (({1'b0, c0_tx.address[1:0]} + {1'b0, c0_tx.cl_len}) <= 3'd3))
    else
    begin
        $error("c0 request crosses a 4-line boundary");
        fail_count++;
    end

    // CCI-P has bursts of 1, 2 and 4 lines, so cl_len is 0, 1 or 3 and never above 3
    cl_len_legal: assert property (@(posedge clk) disable iff (reset)
        (c0_tx.valid |-> (c0_tx.cl_len != 2'd2)) and
        ((c1_tx.valid && c1_tx.sop) |-> (c1_tx.cl_len != 2'd2)))
    else
    begin
        $error("cl_len outside the legal CCI-P burst lengths");
        fail_count++;
    end

    // After the first reset edge both request channels stay idle until reset drops
    quiet_in_reset: assert property (@(posedge clk)
        (reset && $past(reset)) |-> (!c0_tx.valid && !c1_tx.valid))
    else
    begin
        $error("request issued while reset is high");
        fail_count++;
    end

endmodule

bind host_mem_subsys host_mem_subsys_checker checker_i
(
    .clk(clk),
    .reset(reset),
    .c0_tx(c0_tx),
    .c1_tx(c1_tx)
);

//--- tb/host_mem_subsys_tb.sv
// Testbench for the host memory subsystem
// Clock, reset, watchdog, reference line memory, compare tasks, Avalon read
// and write drivers and the five directed tests
`timescale 1ns/10ps

module host_mem_subsys_tb
    import host_chan_pkg::*;
;

    localparam int MAX_BURST = 16;
    localparam int MEM_ADDR_W = 6;
    localparam int LINES = 2**MEM_ADDR_W;
    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 10;
    localparam int TEST_COUNT = 5;
    // Each test gets 200 cycles on top of the reset time
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200 * TEST_COUNT;

    logic              clk = 1'b0;
    logic              reset;
    t_avmm_rd_req      rd_req;
    t_avmm_wr_req      wr_req;
    logic              rd_waitrequest;
    logic              wr_waitrequest;
    logic              rd_readdatavalid;
    logic [DATA_W-1:0] rd_readdata;
    logic              wr_writeresponsevalid;

    // Mirror of the emulator memory and the read data still owed, in request order
    logic [DATA_W-1:0] ref_mem [LINES];
    logic [DATA_W-1:0] exp_q [$];

    integer seed = 78129;
    int     errors = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     stall_cycles = 0;
    int     total_wr_rsp = 0;

    host_mem_subsys #(
        .MAX_BURST(MAX_BURST),
        .MEM_ADDR_W(MEM_ADDR_W)
    ) host_mem_subsys_i (
        .clk(clk),
        .reset(reset),
        .rd_req(rd_req),
        .wr_req(wr_req),
        .rd_waitrequest(rd_waitrequest),
        .wr_waitrequest(wr_waitrequest),
        .rd_readdatavalid(rd_readdatavalid),
        .rd_readdata(rd_readdata),
        .wr_writeresponsevalid(wr_writeresponsevalid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the DUT stopped responding",
                 WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic logic [MEM_ADDR_W-1:0] line_index(input int addr);
        return MEM_ADDR_W'(addr);
    endfunction

    function automatic logic [DATA_W-1:0] random_line();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic compare_line(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                                input string name);
        if (got !== exp)
        begin
            $display("[FAIL] time %0d ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string name);
        if (got != exp)
        begin
            $display("[FAIL] time %0d ns: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before)
        begin
            $display("%s: passed", name);
            tests_passed++;
        end
        else
        begin
            $display("%s: failed with %0d errors", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    // Drives one Avalon write burst and expects exactly one write response for it
    task automatic write_burst(input int addr, input int len);
        logic [DATA_W-1:0] line;
        int                beat;
        int                rsp;
        int                waited;
        beat = 0;
        rsp = 0;
        waited = 0;
        line = random_line();
        ref_mem[line_index(addr)] = line;
        wr_req.write <= 1'b1;
        wr_req.address <= ADDR_W'(addr);
        wr_req.burstcount <= 8'(len);
        wr_req.writedata <= line;
        while (beat < len)
        begin
            @(posedge clk);
            rsp += int'(wr_writeresponsevalid);
            // The beat of the cycle just ended was taken if waitrequest was low
            if (!wr_waitrequest)
            begin
                beat++;
                if (beat < len)
                begin
                    line = random_line();
                    ref_mem[line_index(addr + beat)] = line;
                    wr_req.writedata <= line;
                end
                else
                begin
                    wr_req.write <= 1'b0;
                end
            end
        end
        while ((rsp == 0) && (waited < 50))
        begin
            @(posedge clk);
            rsp += int'(wr_writeresponsevalid);
            waited++;
        end
        if (rsp == 0)
        begin
            $display("No write response arrived for the burst at line %0d", addr);
        end
        // A few quiet cycles catch any extra response for the same burst
        repeat (6)
        begin
            @(posedge clk);
            rsp += int'(wr_writeresponsevalid);
        end
        compare_count(rsp, 1, "wr_writeresponsevalid count");
        total_wr_rsp += rsp;
    endtask

    // Queues the expected lines and holds the read request until it is accepted
    task automatic start_read(input int addr, input int len);
        int i;
        for (i = 0; i < len; i++)
        begin
            exp_q.push_back(ref_mem[line_index(addr + i)]);
        end
        rd_req.read <= 1'b1;
        rd_req.address <= ADDR_W'(addr);
        rd_req.burstcount <= 8'(len);
        do
        begin
            @(posedge clk);
        end
        while (rd_waitrequest);
        rd_req.read <= 1'b0;
    endtask

    // Collects read beats against the queue and checks the total beat count
    task automatic collect_reads(input int beats);
        int got;
        int idle;
        got = 0;
        idle = 0;
        while ((got < beats) && (idle < 100))
        begin
            @(posedge clk);
            stall_cycles += int'(host_mem_subsys_i.fiu_rd_waitrequest);
            if (rd_readdatavalid && (exp_q.size() == 0))
            begin
                $display("Read data arrived at %0d ns with no read outstanding", $time);
                errors++;
                got++;
            end
            else if (rd_readdatavalid)
            begin
                compare_line(rd_readdata, exp_q.pop_front(), "rd_readdata");
                got++;
                idle = 0;
            end
            else
            begin
                idle++;
            end
        end
        repeat (6)
        begin
            @(posedge clk);
            got += int'(rd_readdatavalid);
        end
        compare_count(got, beats, "rd_readdatavalid beats");
        exp_q.delete();
    endtask

    task automatic read_burst_check(input int addr, input int len);
        start_read(addr, len);
        collect_reads(len);
    endtask

    task automatic reset_and_single_line();
        int errors_before;
        errors_before = errors;
        compare_count(int'(rd_waitrequest), 0, "rd_waitrequest");
        compare_count(int'(wr_waitrequest), 0, "wr_waitrequest");
        compare_count(int'(rd_readdatavalid), 0, "rd_readdatavalid");
        compare_count(int'(wr_writeresponsevalid), 0, "wr_writeresponsevalid");
        write_burst(5, 1);
        read_burst_check(5, 1);
        report_test("Reset state and single line", errors_before);
    endtask

    task automatic aligned_four_lines();
        int errors_before;
        errors_before = errors;
        write_burst(8, 4);
        read_burst_check(8, 4);
        report_test("Aligned 4-line burst", errors_before);
    endtask

    // Line 3 starts mid-block, so the write goes out as pieces of 1, 4 and 4
    task automatic unaligned_nine_lines();
        int errors_before;
        errors_before = errors;
        write_burst(3, 9);
        read_burst_check(5, 7);
        read_burst_check(3, 2);
        report_test("Unaligned 9-line burst", errors_before);
    endtask

    // Eight pieces reach the emulator close together and raise its almost-full
    task automatic back_to_back_reads();
        int errors_before;
        int stalls_before;
        errors_before = errors;
        write_burst(16, 16);
        stalls_before = stall_cycles;
        fork
            begin
                start_read(3, 7);
                start_read(10, 2);
                start_read(16, 16);
            end
            collect_reads(25);
        join
        compare_count(int'(stall_cycles > stalls_before), 1, "fiu_rd_waitrequest asserted");
        report_test("Back-to-back reads under back-pressure", errors_before);
    endtask

    task automatic random_bursts();
        int errors_before;
        int rsp_before;
        int addr;
        int len;
        int n;
        errors_before = errors;
        rsp_before = total_wr_rsp;
        for (n = 0; n < 8; n++)
        begin
            addr = int'({$random(seed)} % LINES);
            len = int'({$random(seed)} % MAX_BURST) + 1;
            write_burst(addr, len);
            read_burst_check(addr, len);
        end
        compare_count(total_wr_rsp - rsp_before, 8, "write responses over random bursts");
        report_test("Random bursts", errors_before);
    endtask

    initial
    begin
        rd_req <= '0;
        wr_req <= '0;
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        reset_and_single_line();
        aligned_four_lines();
        unaligned_nine_lines();
        back_to_back_reads();
        random_bursts();

        errors += host_mem_subsys_i.checker_i.fail_count;
        $display("Tests passed: %0d, tests failed: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, host_mem_subsys_i.checker_i.fail_count);
        if ((tests_failed == 0) && (errors == 0))
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
design/host_chan_pkg.sv
design/avmm_burst_splitter.sv
design/ccip_avmm_bridge.sv
design/host_mem_emulator.sv
design/host_mem_subsys.sv
tb/host_mem_subsys_checker.sv
tb/host_mem_subsys_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = host_mem_subsys_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
RUN_FLAGS = +verilator+error+limit+100
PASS_MSG  = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
